//--- Bender.yml
package:
  name: soc_bus

sources:
  - files:
      - hdl/soc_bus_pkg.sv
      - hdl/wb_if.sv
      - hdl/wb_pri_arbiter.sv
      - hdl/uptime_counter.sv
      - hdl/bus_decoder.sv
      - hdl/sys_regs.sv
      - hdl/switch_led_regs.sv
      - hdl/block_ram.sv
      - hdl/soc_bus_top.sv
  - target: simulation
    files:
      - sim/soc_bus_asserts.sv
      - sim/tb_soc_bus_top.sv

//--- hdl/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram #(
    parameter int MEM_AW = soc_bus_pkg::MEM_AW
) (
    input  wire  i_clk,
    wb_if.slave  mem_bus
);

    localparam int DATA_W = soc_bus_pkg::DATA_W;
    localparam int SEL_W  = soc_bus_pkg::SEL_W;

    logic [DATA_W-1:0] mem [2**MEM_AW];
    logic [MEM_AW-1:0] waddr;

    assign waddr = mem_bus.addr[MEM_AW-1:0];

    // byte lanes written independently
    always_ff @(posedge i_clk) begin
        if (mem_bus.stb && mem_bus.we) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (mem_bus.sel[i]) begin
                    mem[waddr][8*i +: 8] <= mem_bus.wdata[8*i +: 8];
                end
            end
        end
    end

    // read data and ack land together
    always_ff @(posedge i_clk) begin
        mem_bus.rdata <= mem[waddr];
        mem_bus.ack   <= mem_bus.cyc && mem_bus.stb;
    end

    assign mem_bus.err   = 1'b0;
    assign mem_bus.stall = 1'b0;

endmodule : block_ram

`default_nettype wire

//--- hdl/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int MEM_AW = soc_bus_pkg::MEM_AW
) (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    wb_if.slave                             shared_bus,
    wb_if.master                            mem_bus,
    wb_if.master                            sys_bus,
    wb_if.master                            swled_bus,
    output logic                            o_fault,
    output logic [soc_bus_pkg::ADDR_W-1:0]  o_fault_addr
);

    localparam int ADDR_W = soc_bus_pkg::ADDR_W;

    logic [soc_bus_pkg::PAGE_MSB-soc_bus_pkg::PAGE_LSB:0] page;
    logic mem_sel;
    logic sys_sel;
    logic swled_sel;
    logic none_sel;

    assign page      = shared_bus.addr[soc_bus_pkg::PAGE_MSB:soc_bus_pkg::PAGE_LSB];
    assign mem_sel   = (page == soc_bus_pkg::MEM_PAGE);
    assign sys_sel   = (page == soc_bus_pkg::SYS_PAGE);
    assign swled_sel = (shared_bus.addr == soc_bus_pkg::SWLED_ADDR);
    assign none_sel  = !mem_sel && !sys_sel && !swled_sel;

    // request fields fan out, stb only to the hit slave
    assign mem_bus.cyc   = shared_bus.cyc;
    assign mem_bus.stb   = shared_bus.stb && mem_sel;
    assign mem_bus.we    = shared_bus.we;
    assign mem_bus.addr  = {{(ADDR_W-MEM_AW){1'b0}}, shared_bus.addr[MEM_AW-1:0]};
    assign mem_bus.wdata = shared_bus.wdata;
    assign mem_bus.sel   = shared_bus.sel;

    assign sys_bus.cyc   = shared_bus.cyc;
    assign sys_bus.stb   = shared_bus.stb && sys_sel;
    assign sys_bus.we    = shared_bus.we;
    assign sys_bus.addr  = shared_bus.addr;
    assign sys_bus.wdata = shared_bus.wdata;
    assign sys_bus.sel   = shared_bus.sel;

    assign swled_bus.cyc   = shared_bus.cyc;
    assign swled_bus.stb   = shared_bus.stb && swled_sel;
    assign swled_bus.we    = shared_bus.we;
    assign swled_bus.addr  = shared_bus.addr;
    assign swled_bus.wdata = shared_bus.wdata;
    assign swled_bus.sel   = shared_bus.sel;

    assign shared_bus.stall = (mem_sel && mem_bus.stall)
                            || (sys_sel && sys_bus.stall)
                            || (swled_sel && swled_bus.stall);

    // unmapped access, error back plus fault report
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            shared_bus.err <= 1'b0;
            shared_bus.ack <= 1'b0;
            o_fault        <= 1'b0;
        end else begin
            shared_bus.err <= (shared_bus.stb && none_sel)
                            || mem_bus.err || sys_bus.err || swled_bus.err;
            shared_bus.ack <= mem_bus.ack || sys_bus.ack || swled_bus.ack;
            o_fault        <= shared_bus.stb && none_sel;
        end
    end

    always_ff @(posedge i_clk) begin
        o_fault_addr <= shared_bus.addr;
        if (mem_bus.ack) begin
            shared_bus.rdata <= mem_bus.rdata;
        end else if (sys_bus.ack) begin
            shared_bus.rdata <= sys_bus.rdata;
        end else if (swled_bus.ack) begin
            shared_bus.rdata <= swled_bus.rdata;
        end else begin
            shared_bus.rdata <= '0;
        end
    end

endmodule : bus_decoder

`default_nettype wire

//--- hdl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // bus widths
    parameter int DATA_W = 32;
    parameter int ADDR_W = 30;
    parameter int SEL_W  = DATA_W / 8;

    // default memory depth in words, as log2
    parameter int MEM_AW = 10;

    // region select field of the word address
    parameter int PAGE_MSB = 29;
    parameter int PAGE_LSB = 21;

    parameter logic [PAGE_MSB-PAGE_LSB:0] MEM_PAGE = 9'h000;
    parameter logic [PAGE_MSB-PAGE_LSB:0] SYS_PAGE = 9'h001;

    // switch/led port sits on a single word
    parameter logic [ADDR_W-1:0] SWLED_ADDR = 30'h0040_0001;

    // system register offsets, address bits 3:0
    parameter logic [3:0] SYS_OFS_ID      = 4'h0;
    parameter logic [3:0] SYS_OFS_SCRATCH = 4'h1;
    parameter logic [3:0] SYS_OFS_FAULT   = 4'h2;
    parameter logic [3:0] SYS_OFS_UPTIME  = 4'h3;
    parameter logic [3:0] SYS_OFS_IRQ     = 4'h4;

    parameter logic [DATA_W-1:0] BOARD_ID = 32'h2019_1028;

    // arbiter grant state
    typedef enum logic {
        OWNER_A,
        OWNER_B
    } owner_t;

endpackage : soc_bus_pkg

`default_nettype wire

//--- hdl/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top #(
    parameter int MEM_AW = soc_bus_pkg::MEM_AW
) (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    // master a, cpu side
    input  wire                             i_a_cyc,
    input  wire                             i_a_stb,
    input  wire                             i_a_we,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   i_a_addr,
    input  wire [soc_bus_pkg::DATA_W-1:0]   i_a_data,
    input  wire [soc_bus_pkg::SEL_W-1:0]    i_a_sel,
    output wire                             o_a_ack,
    output wire                             o_a_stall,
    output wire                             o_a_err,
    output wire [soc_bus_pkg::DATA_W-1:0]   o_a_data,
    // master b, debug side
    input  wire                             i_b_cyc,
    input  wire                             i_b_stb,
    input  wire                             i_b_we,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   i_b_addr,
    input  wire [soc_bus_pkg::DATA_W-1:0]   i_b_data,
    input  wire [soc_bus_pkg::SEL_W-1:0]    i_b_sel,
    output wire                             o_b_ack,
    output wire                             o_b_stall,
    output wire                             o_b_err,
    output wire [soc_bus_pkg::DATA_W-1:0]   o_b_data,
    // board io
    input  wire [15:0]                      i_switches,
    output wire [15:0]                      o_leds,
    output wire                             o_irq
);

    wb_if shared_bus ();
    wb_if mem_bus ();
    wb_if sys_bus ();
    wb_if swled_bus ();

    wire                           fault;
    wire [soc_bus_pkg::ADDR_W-1:0] fault_addr;

    wb_pri_arbiter u_arbiter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_a_cyc    (i_a_cyc),
        .i_a_stb    (i_a_stb),
        .i_a_we     (i_a_we),
        .i_a_addr   (i_a_addr),
        .i_a_data   (i_a_data),
        .i_a_sel    (i_a_sel),
        .o_a_ack    (o_a_ack),
        .o_a_stall  (o_a_stall),
        .o_a_err    (o_a_err),
        .o_a_data   (o_a_data),
        .i_b_cyc    (i_b_cyc),
        .i_b_stb    (i_b_stb),
        .i_b_we     (i_b_we),
        .i_b_addr   (i_b_addr),
        .i_b_data   (i_b_data),
        .i_b_sel    (i_b_sel),
        .o_b_ack    (o_b_ack),
        .o_b_stall  (o_b_stall),
        .o_b_err    (o_b_err),
        .o_b_data   (o_b_data),
        .shared_bus (shared_bus.master)
    );

    bus_decoder #(.MEM_AW(MEM_AW)) u_decoder (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .shared_bus   (shared_bus.slave),
        .mem_bus      (mem_bus.master),
        .sys_bus      (sys_bus.master),
        .swled_bus    (swled_bus.master),
        .o_fault      (fault),
        .o_fault_addr (fault_addr)
    );

    sys_regs u_sys_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .sys_bus      (sys_bus.slave),
        .i_fault      (fault),
        .i_fault_addr (fault_addr),
        .o_irq        (o_irq)
    );

    switch_led_regs u_switch_led (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .swled_bus  (swled_bus.slave),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

    block_ram #(.MEM_AW(MEM_AW)) u_ram (
        .i_clk   (i_clk),
        .mem_bus (mem_bus.slave)
    );

endmodule : soc_bus_top

`default_nettype wire

//--- hdl/switch_led_regs.sv
`timescale 1ns/1ps
`default_nettype none

module switch_led_regs (
    input  wire         i_clk,
    input  wire         i_rst_n,
    wb_if.slave         swled_bus,
    input  wire  [15:0] i_switches,
    output logic [15:0] o_leds
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            swled_bus.ack <= 1'b0;
            o_leds        <= '0;
        end else begin
            swled_bus.ack <= swled_bus.cyc && swled_bus.stb;
            // only the two low byte lanes reach the leds
            if (swled_bus.stb && swled_bus.we) begin
                if (swled_bus.sel[0]) begin
                    o_leds[7:0] <= swled_bus.wdata[7:0];
                end
                if (swled_bus.sel[1]) begin
                    o_leds[15:8] <= swled_bus.wdata[15:8];
                end
            end
        end
    end

    // switches high, leds low, as seen at the strobe
    always_ff @(posedge i_clk) begin
        if (swled_bus.stb) begin
            swled_bus.rdata <= {i_switches, o_leds};
        end
    end

    assign swled_bus.err   = 1'b0;
    assign swled_bus.stall = 1'b0;

endmodule : switch_led_regs

`default_nettype wire

//--- hdl/sys_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    wb_if.slave                             sys_bus,
    input  wire                             i_fault,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   i_fault_addr,
    output logic                            o_irq
);

    localparam int DATA_W = soc_bus_pkg::DATA_W;

    logic [DATA_W-1:0]              scratch;
    logic [soc_bus_pkg::ADDR_W-1:0] fault_addr;
    logic [DATA_W-1:0]              uptime;
    logic                           wr;

    uptime_counter u_uptime (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_count (uptime)
    );

    assign wr = sys_bus.stb && sys_bus.we;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sys_bus.ack <= 1'b0;
            o_irq       <= 1'b0;
            fault_addr  <= '0;
        end else begin
            sys_bus.ack <= sys_bus.cyc && sys_bus.stb;
            if (wr && sys_bus.addr[3:0] == soc_bus_pkg::SYS_OFS_IRQ) begin
                o_irq <= sys_bus.wdata[0];
            end
            // last unmapped word address
            if (i_fault) begin
                fault_addr <= i_fault_addr;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr && sys_bus.addr[3:0] == soc_bus_pkg::SYS_OFS_SCRATCH) begin
            scratch <= sys_bus.wdata;
        end
        case (sys_bus.addr[3:0])
            soc_bus_pkg::SYS_OFS_ID:      sys_bus.rdata <= soc_bus_pkg::BOARD_ID;
            soc_bus_pkg::SYS_OFS_SCRATCH: sys_bus.rdata <= scratch;
            soc_bus_pkg::SYS_OFS_FAULT:   sys_bus.rdata <= {fault_addr, 2'b00};
            soc_bus_pkg::SYS_OFS_UPTIME:  sys_bus.rdata <= uptime;
            soc_bus_pkg::SYS_OFS_IRQ:     sys_bus.rdata <= {{(DATA_W-1){1'b0}}, o_irq};
            default:                      sys_bus.rdata <= '0;
        endcase
    end

    assign sys_bus.err   = 1'b0;
    assign sys_bus.stall = 1'b0;

endmodule : sys_regs

`default_nettype wire

//--- hdl/uptime_counter.sv
`timescale 1ns/1ps
`default_nettype none

module uptime_counter (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    output logic [soc_bus_pkg::DATA_W-1:0]  o_count
);

    localparam int MSB = soc_bus_pkg::DATA_W - 1;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (!o_count[MSB]) begin
            o_count <= o_count + 1'b1;
        end else begin
            // top bit sticks, the rest keeps wrapping
            o_count[MSB-1:0] <= o_count[MSB-1:0] + 1'b1;
        end
    end

endmodule : uptime_counter

`default_nettype wire

//--- hdl/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    // request side, from the master
    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [soc_bus_pkg::ADDR_W-1:0]   addr;
    logic [soc_bus_pkg::DATA_W-1:0]   wdata;
    logic [soc_bus_pkg::SEL_W-1:0]    sel;

    // response side, from the slave
    logic                             ack;
    logic                             err;
    logic [soc_bus_pkg::DATA_W-1:0]   rdata;
    logic                             stall;

    modport master (
        output cyc, stb, we, addr, wdata, sel,
        input  ack, err, rdata, stall
    );

    modport slave (
        input  cyc, stb, we, addr, wdata, sel,
        output ack, err, rdata, stall
    );

endinterface : wb_if

`default_nettype wire

//--- hdl/wb_pri_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pri_arbiter (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    // master a, higher priority
    input  wire                             i_a_cyc,
    input  wire                             i_a_stb,
    input  wire                             i_a_we,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   i_a_addr,
    input  wire [soc_bus_pkg::DATA_W-1:0]   i_a_data,
    input  wire [soc_bus_pkg::SEL_W-1:0]    i_a_sel,
    output logic                            o_a_ack,
    output logic                            o_a_stall,
    output logic                            o_a_err,
    output logic [soc_bus_pkg::DATA_W-1:0]  o_a_data,
    // master b
    input  wire                             i_b_cyc,
    input  wire                             i_b_stb,
    input  wire                             i_b_we,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   i_b_addr,
    input  wire [soc_bus_pkg::DATA_W-1:0]   i_b_data,
    input  wire [soc_bus_pkg::SEL_W-1:0]    i_b_sel,
    output logic                            o_b_ack,
    output logic                            o_b_stall,
    output logic                            o_b_err,
    output logic [soc_bus_pkg::DATA_W-1:0]  o_b_data,
    // merged bus
    wb_if.master                            shared_bus
);

    soc_bus_pkg::owner_t owner;
    logic                a_owns;

    // grant only moves while the owner is idle, a wins a tie
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner <= soc_bus_pkg::OWNER_A;
        end else if ((a_owns && !i_a_cyc) || (!a_owns && !i_b_cyc)) begin
            owner <= (i_b_cyc && !i_a_cyc) ? soc_bus_pkg::OWNER_B : soc_bus_pkg::OWNER_A;
        end
    end

    assign a_owns = (owner == soc_bus_pkg::OWNER_A);

    assign shared_bus.cyc   = a_owns ? i_a_cyc  : i_b_cyc;
    assign shared_bus.stb   = a_owns ? i_a_stb  : i_b_stb;
    assign shared_bus.we    = a_owns ? i_a_we   : i_b_we;
    assign shared_bus.addr  = a_owns ? i_a_addr : i_b_addr;
    assign shared_bus.wdata = a_owns ? i_a_data : i_b_data;
    assign shared_bus.sel   = a_owns ? i_a_sel  : i_b_sel;

    // responses go back to the owner only
    assign o_a_ack  = a_owns && shared_bus.ack;
    assign o_a_err  = a_owns && shared_bus.err;
    assign o_a_data = a_owns ? shared_bus.rdata : '0;
    assign o_b_ack  = !a_owns && shared_bus.ack;
    assign o_b_err  = !a_owns && shared_bus.err;
    assign o_b_data = a_owns ? '0 : shared_bus.rdata;

    // the waiting master is held off while it strobes
    assign o_a_stall = a_owns ? shared_bus.stall : i_a_stb;
    assign o_b_stall = a_owns ? i_b_stb : shared_bus.stall;

endmodule : wb_pri_arbiter

`default_nettype wire

//--- sim/soc_bus_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_asserts (
    input wire        i_clk,
    input wire        i_rst_n,
    input wire        i_a_cyc,
    input wire        i_a_stb,
    input wire [29:0] i_a_addr,
    input wire        o_a_ack,
    input wire        o_a_err,
    input wire        o_a_stall,
    input wire        i_b_cyc,
    input wire        i_b_stb,
    input wire [29:0] i_b_addr,
    input wire        o_b_ack,
    input wire        o_b_err,
    input wire        o_b_stall,
    input wire        i_owner
);

    // running count of failed properties
    int fail_count = 0;

    // no region claims this word address
    function automatic logic unmapped(input logic [29:0] addr);
        logic [8:0] page;
        page = addr[soc_bus_pkg::PAGE_MSB:soc_bus_pkg::PAGE_LSB];
        return (page != soc_bus_pkg::MEM_PAGE) && (page != soc_bus_pkg::SYS_PAGE)
            && (addr != soc_bus_pkg::SWLED_ADDR);
    endfunction

    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_a_ack && o_a_err))
        else begin
            fail_count++;
            $error("port a ack and err high together");
        end
    b_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_b_ack && o_b_err))
        else begin
            fail_count++;
            $error("port b ack and err high together");
        end

    a_ack_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_a_ack |-> i_a_cyc)
        else begin
            fail_count++;
            $error("port a ack outside its cycle");
        end
    b_ack_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_b_ack |-> i_b_cyc)
        else begin
            fail_count++;
            $error("port b ack outside its cycle");
        end

    // port a is only held off while b owns the bus
    a_stall_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_owner != soc_bus_pkg::OWNER_B && i_a_cyc && i_a_stb) |-> !o_a_stall)
        else begin
            fail_count++;
            $error("port a stalled while it owns the bus");
        end

    a_unmapped_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_a_cyc && i_a_stb && !o_a_stall && unmapped(i_a_addr)) |=> o_a_err)
        else begin
            fail_count++;
            $error("port a unmapped access without err");
        end
    b_unmapped_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_b_cyc && i_b_stb && !o_b_stall && unmapped(i_b_addr)) |=> o_b_err)
        else begin
            fail_count++;
            $error("port b unmapped access without err");
        end

endmodule : soc_bus_asserts

bind soc_bus_top soc_bus_asserts u_soc_bus_asserts (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_a_cyc   (i_a_cyc),
    .i_a_stb   (i_a_stb),
    .i_a_addr  (i_a_addr),
    .o_a_ack   (o_a_ack),
    .o_a_err   (o_a_err),
    .o_a_stall (o_a_stall),
    .i_b_cyc   (i_b_cyc),
    .i_b_stb   (i_b_stb),
    .i_b_addr  (i_b_addr),
    .o_b_ack   (o_b_ack),
    .o_b_err   (o_b_err),
    .o_b_stall (o_b_stall),
    .i_owner   (u_arbiter.owner)
);

`default_nettype wire

//--- sim/tb_soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus_top;

    localparam int          MEM_AW     = 10;
    localparam int          WAIT_LIMIT = 50;
    localparam logic [29:0] SYS_BASE   = 30'h0020_0000;
    localparam logic [29:0] SWLED      = 30'h0040_0001;
    localparam logic [29:0] HOLE       = 30'h0060_0010;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_a_cyc;
    logic        i_a_stb;
    logic        i_a_we;
    logic [29:0] i_a_addr;
    logic [31:0] i_a_data;
    logic [3:0]  i_a_sel;
    wire         o_a_ack;
    wire         o_a_stall;
    wire         o_a_err;
    wire  [31:0] o_a_data;
    logic        i_b_cyc;
    logic        i_b_stb;
    logic        i_b_we;
    logic [29:0] i_b_addr;
    logic [31:0] i_b_data;
    logic [3:0]  i_b_sel;
    wire         o_b_ack;
    wire         o_b_stall;
    wire         o_b_err;
    wire  [31:0] o_b_data;
    logic [15:0] i_switches;
    wire  [15:0] o_leds;
    wire         o_irq;

    int data_errors  = 0;
    int proto_errors = 0;
    int timeouts     = 0;

    // expected read data per port with its mask in the upper word
    logic [63:0] exp_a_q[$];
    logic [63:0] exp_b_q[$];

    // reference state of the board
    logic [31:0] shadow [2**MEM_AW];
    logic [31:0] scratch_ref;
    logic        irq_ref;
    logic [15:0] led_ref;
    logic [29:0] fault_ref;

    soc_bus_top #(.MEM_AW(MEM_AW)) i_soc_bus_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    // what a read of addr must return after the writes so far
    function automatic logic [31:0] ref_read(input logic [29:0] addr);
        if (addr[29:21] == 9'd0) begin
            return shadow[addr[MEM_AW-1:0]];
        end else if (addr == SWLED) begin
            return {i_switches, led_ref};
        end else if (addr[29:21] == 9'd1) begin
            case (addr[3:0])
                4'h0:    return 32'h2019_1028;
                4'h1:    return scratch_ref;
                4'h2:    return {fault_ref, 2'b00};
                4'h4:    return {31'd0, irq_ref};
                default: return 32'd0;
            endcase
        end
        return 32'd0;
    endfunction

    task automatic ref_write(input logic [29:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
        logic [31:0] tmp;
        if (addr[29:21] == 9'd0) begin
            shadow[addr[MEM_AW-1:0]] = merge_bytes(shadow[addr[MEM_AW-1:0]], data, sel);
        end else if (addr == SWLED) begin
            tmp = merge_bytes({16'd0, led_ref}, data, sel);
            led_ref = tmp[15:0];
        end else if (addr[29:21] == 9'd1 && addr[3:0] == 4'h1) begin
            scratch_ref = data;
        end else if (addr[29:21] == 9'd1 && addr[3:0] == 4'h4) begin
            irq_ref = data[0];
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input logic [31:0] mask);
        assert ((got & mask) === (exp & mask)) else begin
            data_errors++;
            $display("Error: %0t %s got %h expected %h", $time, name, got & mask, exp & mask);
        end
    endtask

    task automatic drive_port(input bit port_b, input bit cyc, input bit stb, input bit we,
                              input logic [29:0] addr, input logic [31:0] data,
                              input logic [3:0] sel);
        if (port_b) begin
            i_b_cyc  = cyc;
            i_b_stb  = stb;
            i_b_we   = we;
            i_b_addr = addr;
            i_b_data = data;
            i_b_sel  = sel;
        end else begin
            i_a_cyc  = cyc;
            i_a_stb  = stb;
            i_a_we   = we;
            i_a_addr = addr;
            i_a_data = data;
            i_a_sel  = sel;
        end
    endtask

    // one pipelined transfer where lat counts edges from acceptance to ack or err
    task automatic bus_access(input bit port_b, input bit we, input logic [29:0] addr,
                              input logic [31:0] data, input logic [3:0] sel,
                              input bit expect_ack, input logic [63:0] entry,
                              output logic [31:0] rdata, output bit got_err,
                              output int lat, output int stalls);
        int n;
        bit stall_now;
        bit accepted;
        bit ack_now;
        bit err_now;
        @(negedge i_clk);
        if (expect_ack) begin
            if (port_b) begin
                exp_b_q.push_back(entry);
            end else begin
                exp_a_q.push_back(entry);
            end
        end
        drive_port(port_b, 1'b1, 1'b1, we, addr, data, sel);
        stalls = 0;
        n = 0;
        do begin
            @(posedge i_clk);
            stall_now = port_b ? o_b_stall : o_a_stall;
            stalls += stall_now;
            n++;
        end while (stall_now && n < WAIT_LIMIT);
        accepted = !stall_now;
        assert (accepted) else begin
            timeouts++;
            $display("port %s was never granted the bus at %0t", port_b ? "b" : "a", $time);
        end
        @(negedge i_clk);
        drive_port(port_b, accepted, 1'b0, we, addr, data, sel);
        lat = 0;
        ack_now = 1'b0;
        err_now = 1'b0;
        while (accepted && !ack_now && !err_now && lat < WAIT_LIMIT) begin
            @(posedge i_clk);
            lat++;
            ack_now = port_b ? o_b_ack : o_a_ack;
            err_now = port_b ? o_b_err : o_a_err;
            rdata   = port_b ? o_b_data : o_a_data;
        end
        assert (!accepted || ack_now || err_now) else begin
            timeouts++;
            $display("no ack or err on port %s at %0t", port_b ? "b" : "a", $time);
        end
        assert (!(err_now && expect_ack)) else begin
            proto_errors++;
            $display("port %s got err for a mapped address at %0t", port_b ? "b" : "a", $time);
        end
        if (err_now) begin
            // no ack may follow the err while cyc stays up
            repeat (2) begin
                @(posedge i_clk);
                assert (!(port_b ? o_b_ack : o_a_ack)) else begin
                    proto_errors++;
                    $display("ack followed an err at %0t", $time);
                end
            end
        end
        got_err = err_now;
        @(negedge i_clk);
        drive_port(port_b, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic write_word(input bit port_b, input logic [29:0] addr,
                              input logic [31:0] data, input logic [3:0] sel);
        logic [31:0] rdata;
        bit          got_err;
        int          lat;
        int          stalls;
        ref_write(addr, data, sel);
        bus_access(port_b, 1'b1, addr, data, sel, 1'b1, 64'd0, rdata, got_err, lat, stalls);
    endtask

    task automatic read_word(input bit port_b, input logic [29:0] addr,
                             input logic [31:0] mask, output logic [31:0] rdata,
                             output int lat, output int stalls);
        bit got_err;
        bus_access(port_b, 1'b0, addr, '0, 4'hF, 1'b1, {mask, ref_read(addr)},
                   rdata, got_err, lat, stalls);
    endtask

    // every ack is matched with the oldest expectation of its port
    always @(posedge i_clk) begin : compare_acks
        logic [63:0] entry;
        if (o_a_ack) begin
            assert (exp_a_q.size() > 0) else begin
                proto_errors++;
                $display("ack on port a with nothing outstanding at %0t", $time);
            end
            if (exp_a_q.size() > 0) begin
                entry = exp_a_q.pop_front();
                check_word("o_a_data", o_a_data, entry[31:0], entry[63:32]);
            end
        end
        if (o_b_ack) begin
            assert (exp_b_q.size() > 0) else begin
                proto_errors++;
                $display("ack on port b with nothing outstanding at %0t", $time);
            end
            if (exp_b_q.size() > 0) begin
                entry = exp_b_q.pop_front();
                check_word("o_b_data", o_b_data, entry[31:0], entry[63:32]);
            end
        end
    end

    initial begin
        logic [29:0] addrs [8];
        logic [31:0] rdata;
        logic [31:0] rd_b;
        logic [31:0] up1;
        bit          got_err;
        int          lat;
        int          lat_b;
        int          stalls_a;
        int          stalls_b;
        int          assert_fails;
        time         done_a;
        time         done_b;

        void'($urandom(24));
        i_rst_n    = 1'b0;
        i_switches = '0;
        drive_port(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        irq_ref   = 1'b0;
        led_ref   = '0;
        fault_ref = '0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // full memory words first so every lane is known
        for (int i = 0; i < 8; i++) begin
            addrs[i] = 30'($urandom % (2**MEM_AW));
            write_word(1'b0, addrs[i], $urandom, 4'hF);
        end
        for (int i = 0; i < 16; i++) begin
            write_word(1'b0, addrs[$urandom % 8], $urandom, 4'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            read_word(1'b0, addrs[i], '1, rdata, lat, stalls_a);
            check_word("ack latency", 32'(lat), 32'd2, '1);
        end

        // system registers
        read_word(1'b0, SYS_BASE | 30'h0, '1, rdata, lat, stalls_a);
        write_word(1'b0, SYS_BASE | 30'h1, $urandom, 4'hF);
        read_word(1'b0, SYS_BASE | 30'h1, '1, rdata, lat, stalls_a);
        write_word(1'b0, SYS_BASE | 30'h4, 32'd1, 4'hF);
        check_word("o_irq", {31'd0, o_irq}, 32'd1, '1);
        read_word(1'b0, SYS_BASE | 30'h4, '1, rdata, lat, stalls_a);
        write_word(1'b0, SYS_BASE | 30'h4, 32'd0, 4'hF);
        check_word("o_irq", {31'd0, o_irq}, 32'd0, '1);
        read_word(1'b0, SYS_BASE | 30'h7, '1, rdata, lat, stalls_a);

        // unmapped read and then the fault register
        bus_access(1'b0, 1'b0, HOLE, '0, 4'hF, 1'b0, 64'd0, rdata, got_err, lat, stalls_a);
        assert (got_err) else begin
            proto_errors++;
            $display("unmapped read returned no err at %0t", $time);
        end
        check_word("err latency", 32'(lat), 32'd1, '1);
        fault_ref = HOLE;
        read_word(1'b0, SYS_BASE | 30'h2, '1, rdata, lat, stalls_a);

        // uptime moves forward
        read_word(1'b0, SYS_BASE | 30'h3, '0, up1, lat, stalls_a);
        read_word(1'b0, SYS_BASE | 30'h3, '0, rdata, lat, stalls_a);
        assert (rdata > up1) else begin
            data_errors++;
            $display("Error: %0t uptime got %h expected above %h", $time, rdata, up1);
        end

        // switch and led port
        @(negedge i_clk);
        i_switches = 16'($urandom);
        write_word(1'b0, SWLED, $urandom, 4'b0001);
        check_word("o_leds", {16'd0, o_leds}, {16'd0, led_ref}, '1);
        write_word(1'b0, SWLED, $urandom, 4'b0010);
        check_word("o_leds", {16'd0, o_leds}, {16'd0, led_ref}, '1);
        read_word(1'b0, SWLED, '1, rdata, lat, stalls_a);

        // both masters request in the same cycle and a goes first
        fork
            begin
                read_word(1'b0, addrs[0], '1, rdata, lat, stalls_a);
                done_a = $time;
            end
            begin
                read_word(1'b1, addrs[1], '1, rd_b, lat_b, stalls_b);
                done_b = $time;
            end
        join
        check_word("port a stall cycles", 32'(stalls_a), 32'd0, '1);
        assert (stalls_b > 0 && done_b > done_a) else begin
            proto_errors++;
            $display("port b was not held off behind port a");
        end
        check_word("port b ack latency", 32'(lat_b), 32'd2, '1);

        repeat (4) @(posedge i_clk);
        assert_fails = i_soc_bus_top.u_soc_bus_asserts.fail_count;
        $display("data errors %0d, protocol errors %0d, timeouts %0d, assertion failures %0d",
                 data_errors, proto_errors, timeouts, assert_fails);
        if (data_errors + proto_errors + timeouts + assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_soc_bus_top

`default_nettype wire

//--- soc_bus_top.f
hdl/soc_bus_pkg.sv
hdl/wb_if.sv
hdl/wb_pri_arbiter.sv
hdl/uptime_counter.sv
hdl/bus_decoder.sv
hdl/sys_regs.sv
hdl/switch_led_regs.sv
hdl/block_ram.sv
hdl/soc_bus_top.sv
sim/soc_bus_asserts.sv
sim/tb_soc_bus_top.sv
